// ==== hw/dram_ctrl_regs.sv ====
// DRAM control terminal
// holds the memory reset bit and a status word sampled from the
// memory controller flags

`timescale 1ns/1ps

module dram_ctrl_regs import host_pkg::*; (
   input  logic        ifclk,
   input  logic        rst,
   input  logic        ctrl_write,
   input  logic [31:0] reg_addr,
   input  reg_word_t   reg_datai,
   output reg_word_t   ctrl_datao,
   // memory controller flags
   input  logic        calib_done,
   input  logic        wr_error,
   input  logic        wr_underrun,
   input  logic        rd_error,
   input  logic        rd_overflow,
   output logic        mem_rst
);

   logic       reset_bit;
   logic [4:0] status_q;

   // software reset of the memory controller
   always_ff @(posedge ifclk) begin
      if (rst) begin
         reset_bit <= 1'b0;
      end else if (ctrl_write && reg_addr == CTRL_REG_RESET) begin
         reset_bit <= reg_datai[0];
      end
   end

   // flags sampled once on ifclk
   // bit 0 calib_done, then the two write and the two read flags
   always_ff @(posedge ifclk) begin
      status_q <= {rd_overflow, rd_error, wr_underrun, wr_error, calib_done};
   end

   // register read-back, selected by address
   always_comb begin
      case (reg_addr)
         CTRL_REG_RESET: begin
            ctrl_datao = {15'd0, reset_bit};
         end
         CTRL_REG_STATUS: begin
            ctrl_datao = {11'd0, status_q};
         end
         default: begin
            ctrl_datao = '0;
         end
      endcase
   end

   // controller held in reset by the core reset or by software
   assign mem_rst = rst | reset_bit;

endmodule

// ==== hw/dram_read_path.sv ====
// DRAM read path
// splits a host read into port read commands of at most BURST_WORDS
// words and hands each popped word back as two 16-bit halves

`timescale 1ns/1ps

module dram_read_path import host_pkg::*; #(
   parameter int BURST_WORDS = 16
) (
   input  logic        ifclk,
   input  logic        rst,
   input  logic        read_mode,
   input  logic        read,
   input  logic [31:0] reg_addr,
   input  logic [31:0] len,
   output reg_word_t   datao,
   output logic        read_rdy,
   input  logic        cmd_full,
   input  logic        rd_empty,
   input  logic [31:0] rd_data,
   output logic        rd_cmd_en,
   output burst_len_t  rd_cmd_bl,
   output byte_addr_t  rd_cmd_addr,
   output logic        rd_en
);

   localparam int CNT_W = $clog2(BURST_WORDS + 1);

   logic             mode_q;
   logic             mode_rise;
   logic             mode_fall;
   logic [32:0]      len_inc;
   logic [31:0]      words_left;
   logic [31:0]      halves_left;
   logic [CNT_W-1:0] burst_n;
   logic [CNT_W-1:0] pop_left;
   byte_addr_t       addr;
   mem_word_u        hold;
   logic             hold_valid;
   logic             half_sel;

   assign mode_rise = read_mode & ~mode_q;
   assign mode_fall = ~read_mode & mode_q;

   // port words needed for len host words, rounded up
   assign len_inc = {1'b0, len} + 33'd1;

   // size of the next command
   assign burst_n = (words_left >= 32'(BURST_WORDS)) ? CNT_W'(BURST_WORDS)
                                                     : words_left[CNT_W-1:0];

   // next command only once the previous one is fully popped
   assign rd_cmd_en   = (words_left != '0) & (pop_left == '0) & ~cmd_full;
   assign rd_cmd_bl   = burst_len_t'(burst_n - 1'b1);
   assign rd_cmd_addr = addr;

   assign rd_en    = (pop_left != '0) & ~rd_empty & ~hold_valid;
   assign read_rdy = hold_valid & (halves_left != '0);
   assign datao    = half_sel ? hold.half[1] : hold.half[0];

   always_ff @(posedge ifclk) begin
      if (rst) begin
         mode_q      <= 1'b0;
         words_left  <= '0;
         halves_left <= '0;
         pop_left    <= '0;
         hold_valid  <= 1'b0;
         half_sel    <= 1'b0;
      end else begin
         mode_q <= read_mode;

         if (mode_rise) begin
            words_left  <= len_inc[32:1];
            halves_left <= len;
         end else if (mode_fall) begin
            // stop early, words still owed by the port are drained
            words_left  <= '0;
            halves_left <= '0;
         end else begin
            if (rd_cmd_en) begin
               words_left <= words_left - 32'(burst_n);
            end
            if (read) begin
               halves_left <= halves_left - 1'b1;
            end
         end

         if (rd_cmd_en) begin
            pop_left <= burst_n;
         end else if (rd_en) begin
            pop_left <= pop_left - 1'b1;
         end

         if (rd_en) begin
            hold_valid <= 1'b1;
            half_sel   <= 1'b0;
         end else if (read) begin
            half_sel <= ~half_sel;
            if (half_sel) begin
               hold_valid <= 1'b0;
            end
         end else if (hold_valid && halves_left == '0) begin
            // high half past the end of an odd length
            hold_valid <= 1'b0;
         end
      end
   end

   always_ff @(posedge ifclk) begin
      if (rd_en) begin
         hold.word <= rd_data;
      end
   end

   always_ff @(posedge ifclk) begin
      if (mode_rise) begin
         addr <= reg_addr[29:0];
      end else if (rd_cmd_en) begin
         addr <= addr + (byte_addr_t'(burst_n) << 2);
      end
   end

endmodule

// ==== hw/dram_write_path.sv ====
// DRAM write path
// packs pairs of 16-bit host words into port words, pushes them and
// issues write commands of at most BURST_WORDS words each

`timescale 1ns/1ps

module dram_write_path import host_pkg::*; #(
   parameter int BURST_WORDS = 16
) (
   input  logic        ifclk,
   input  logic        rst,
   input  logic        write_mode,
   input  logic        write,
   input  logic [31:0] reg_addr,
   input  reg_word_t   reg_datai,
   output logic        write_rdy,
   input  logic        cmd_full,
   input  logic        wr_full,
   output logic        wr_cmd_en,
   output burst_len_t  wr_cmd_bl,
   output byte_addr_t  wr_cmd_addr,
   output logic        wr_en,
   output logic [31:0] wr_data
);

   localparam int CNT_W = $clog2(BURST_WORDS + 1);

   logic             mode_q;
   logic             mode_rise;
   logic             mode_fall;
   logic             half_valid;
   logic             flush;
   logic [CNT_W-1:0] word_cnt;
   byte_addr_t       addr;
   mem_word_u        wr_word;

   logic             burst_full;
   logic             half_push;
   logic             final_cmd;
   logic             cmd_wait;

   assign mode_rise = write_mode & ~mode_q;
   assign mode_fall = ~write_mode & mode_q;

   assign burst_full = (word_cnt == CNT_W'(BURST_WORDS));
   // end of transfer, push a lone low half with a zero high half
   assign half_push  = flush & half_valid & ~wr_en & ~burst_full & ~wr_full;
   // end of transfer, command for the words left in a partial burst
   assign final_cmd  = flush & ~half_valid & ~wr_en & (word_cnt != '0);
   assign cmd_wait   = burst_full | final_cmd;

   assign wr_cmd_en   = cmd_wait & ~cmd_full;
   assign wr_cmd_bl   = burst_len_t'(word_cnt - 1'b1);
   assign wr_cmd_addr = addr;
   assign write_rdy   = ~wr_full & ~cmd_full & ~cmd_wait;
   assign wr_data     = wr_word.word;

   always_ff @(posedge ifclk) begin
      if (rst) begin
         mode_q     <= 1'b0;
         half_valid <= 1'b0;
         wr_en      <= 1'b0;
         flush      <= 1'b0;
         word_cnt   <= '0;
      end else begin
         mode_q <= write_mode;
         wr_en  <= 1'b0;

         // first strobe low half, second strobe high half and push
         if (write) begin
            half_valid <= ~half_valid;
            wr_en      <= half_valid;
         end else if (half_push) begin
            half_valid <= 1'b0;
            wr_en      <= 1'b1;
         end

         if (wr_cmd_en) begin
            word_cnt <= '0;
         end else if (wr_en) begin
            word_cnt <= word_cnt + 1'b1;
         end

         if (mode_fall) begin
            flush <= 1'b1;
         end else if (flush && !half_valid && !wr_en &&
                      (word_cnt == '0 || wr_cmd_en)) begin
            flush <= 1'b0;
         end
      end
   end

   // payload, only the half being written changes
   always_ff @(posedge ifclk) begin
      if (write && !half_valid) begin
         wr_word.half[0] <= reg_datai;
      end else if (write) begin
         wr_word.half[1] <= reg_datai;
      end else if (half_push) begin
         wr_word.half[1] <= '0;
      end
   end

   // byte address, latched at start and advanced per command
   always_ff @(posedge ifclk) begin
      if (mode_rise) begin
         addr <= reg_addr[29:0];
      end else if (wr_cmd_en) begin
         addr <= addr + (byte_addr_t'(word_cnt) << 2);
      end
   end

endmodule

// ==== hw/host_core.sv ====
// host register and DRAM bridge core
// routes host transfers to the DRAM port, the DRAM control terminal
// or the dummy terminal, and drives the memory controller user port

`timescale 1ns/1ps

module host_core import host_pkg::*; #(
   parameter int BURST_WORDS = 16
) (
   input  logic        ifclk,
   input  logic        rst,
   // host link
   input  term_addr_t  term_addr,
   input  logic [31:0] reg_addr,
   input  logic [31:0] len,
   input  logic        read_mode,
   input  logic        read,
   input  logic        write_mode,
   input  logic        write,
   input  reg_word_t   reg_datai,
   output reg_word_t   reg_datao,
   output logic        read_rdy,
   output logic        write_rdy,
   // memory controller user port
   output logic        cmd_en,
   output logic [2:0]  cmd_instr,
   output burst_len_t  cmd_bl,
   output byte_addr_t  cmd_byte_addr,
   output logic        wr_en,
   output logic [31:0] wr_data,
   output logic        rd_en,
   output logic        mem_rst,
   input  logic        cmd_full,
   input  logic        wr_full,
   input  logic        rd_empty,
   input  logic [31:0] rd_data,
   input  logic        calib_done,
   input  logic        wr_error,
   input  logic        wr_underrun,
   input  logic        rd_error,
   input  logic        rd_overflow
);

   logic       dram_read_mode, dram_read, dram_write_mode, dram_write;
   logic       ctrl_write;
   reg_word_t  dram_datao, ctrl_datao;
   logic       dram_read_rdy, dram_write_rdy;

   logic       wr_cmd_en, rd_cmd_en;
   burst_len_t wr_cmd_bl, rd_cmd_bl;
   byte_addr_t wr_cmd_addr, rd_cmd_addr;

   term_router router_i (
      .term_addr       (term_addr),
      .read_mode       (read_mode),
      .read            (read),
      .write_mode      (write_mode),
      .write           (write),
      .dram_read_mode  (dram_read_mode),
      .dram_read       (dram_read),
      .dram_write_mode (dram_write_mode),
      .dram_write      (dram_write),
      .ctrl_write      (ctrl_write),
      .dram_datao      (dram_datao),
      .ctrl_datao      (ctrl_datao),
      .dram_read_rdy   (dram_read_rdy),
      .dram_write_rdy  (dram_write_rdy),
      .reg_datao       (reg_datao),
      .read_rdy        (read_rdy),
      .write_rdy       (write_rdy)
   );

   dram_ctrl_regs ctrl_i (
      .ifclk       (ifclk),
      .rst         (rst),
      .ctrl_write  (ctrl_write),
      .reg_addr    (reg_addr),
      .reg_datai   (reg_datai),
      .ctrl_datao  (ctrl_datao),
      .calib_done  (calib_done),
      .wr_error    (wr_error),
      .wr_underrun (wr_underrun),
      .rd_error    (rd_error),
      .rd_overflow (rd_overflow),
      .mem_rst     (mem_rst)
   );

   dram_write_path #(.BURST_WORDS(BURST_WORDS)) wr_path_i (
      .ifclk       (ifclk),
      .rst         (rst),
      .write_mode  (dram_write_mode),
      .write       (dram_write),
      .reg_addr    (reg_addr),
      .reg_datai   (reg_datai),
      .write_rdy   (dram_write_rdy),
      .cmd_full    (cmd_full),
      .wr_full     (wr_full),
      .wr_cmd_en   (wr_cmd_en),
      .wr_cmd_bl   (wr_cmd_bl),
      .wr_cmd_addr (wr_cmd_addr),
      .wr_en       (wr_en),
      .wr_data     (wr_data)
   );

   dram_read_path #(.BURST_WORDS(BURST_WORDS)) rd_path_i (
      .ifclk       (ifclk),
      .rst         (rst),
      .read_mode   (dram_read_mode),
      .read        (dram_read),
      .reg_addr    (reg_addr),
      .len         (len),
      .datao       (dram_datao),
      .read_rdy    (dram_read_rdy),
      .cmd_full    (cmd_full),
      .rd_empty    (rd_empty),
      .rd_data     (rd_data),
      .rd_cmd_en   (rd_cmd_en),
      .rd_cmd_bl   (rd_cmd_bl),
      .rd_cmd_addr (rd_cmd_addr),
      .rd_en       (rd_en)
   );

   // the two modes are exclusive so only one path requests at a time
   assign cmd_en        = wr_cmd_en | rd_cmd_en;
   assign cmd_instr     = rd_cmd_en ? CMD_READ : CMD_WRITE;
   assign cmd_bl        = rd_cmd_en ? rd_cmd_bl : wr_cmd_bl;
   assign cmd_byte_addr = rd_cmd_en ? rd_cmd_addr : wr_cmd_addr;

endmodule

// ==== hw/host_pkg.sv ====
// shared definitions for the host register and DRAM bridge core
// terminal codes, port command codes and the common word types

package host_pkg;

   // host side words
   typedef logic [15:0] term_addr_t;
   typedef logic [15:0] reg_word_t;

   // memory controller user port fields
   typedef logic [29:0] byte_addr_t;
   typedef logic [5:0]  burst_len_t;

   // one port word, seen whole by the port and as two halves by the host
   // half[0] is the low half and goes first on the host link
   typedef union packed {
      logic [31:0]        word;
      reg_word_t [1:0]    half;
   } mem_word_u;

   // terminal numbers
   parameter term_addr_t TERM_DRAM      = 16'h0010;
   parameter term_addr_t TERM_DRAM_CTRL = 16'h0011;
   parameter term_addr_t TERM_DUMMY     = 16'h00FF;

   // port instructions
   parameter logic [2:0] CMD_WRITE = 3'b000;
   parameter logic [2:0] CMD_READ  = 3'b001;

   // fixed identification word of the dummy terminal
   parameter reg_word_t DUMMY_WORD = 16'h9988;

   // DRAM control terminal register map
   parameter logic [31:0] CTRL_REG_RESET  = 32'd0;
   parameter logic [31:0] CTRL_REG_STATUS = 32'd1;

endpackage

// ==== hw/term_router.sv ====
// terminal router
// qualifies host modes and strobes for the addressed terminal and
// selects that terminal's read data and ready levels

`timescale 1ns/1ps

module term_router import host_pkg::*; (
   input  term_addr_t term_addr,
   input  logic       read_mode,
   input  logic       read,
   input  logic       write_mode,
   input  logic       write,
   // qualified signals towards the terminals
   output logic       dram_read_mode,
   output logic       dram_read,
   output logic       dram_write_mode,
   output logic       dram_write,
   output logic       ctrl_write,
   // terminal responses
   input  reg_word_t  dram_datao,
   input  reg_word_t  ctrl_datao,
   input  logic       dram_read_rdy,
   input  logic       dram_write_rdy,
   // back to the host link
   output reg_word_t  reg_datao,
   output logic       read_rdy,
   output logic       write_rdy
);

   logic is_dram;
   logic is_ctrl;
   logic is_dummy;

   // one compare per terminal, shared by qualifiers and mux
   assign is_dram  = (term_addr == TERM_DRAM);
   assign is_ctrl  = (term_addr == TERM_DRAM_CTRL);
   assign is_dummy = (term_addr == TERM_DUMMY);

   assign dram_read_mode  = is_dram & read_mode;
   assign dram_read       = is_dram & read;
   assign dram_write_mode = is_dram & write_mode;
   assign dram_write      = is_dram & write;
   // control registers only care about the write strobe
   assign ctrl_write      = is_ctrl & write;

   always_comb begin
      if (is_dram) begin
         reg_datao = dram_datao;
         read_rdy  = dram_read_rdy;
         write_rdy = dram_write_rdy;
      end else if (is_ctrl) begin
         reg_datao = ctrl_datao;
         read_rdy  = 1'b1;
         write_rdy = 1'b1;
      end else if (is_dummy) begin
         reg_datao = DUMMY_WORD;
         read_rdy  = 1'b1;
         write_rdy = 1'b1;
      end else begin
         // unknown terminal reads zero and never stalls the host
         reg_datao = '0;
         read_rdy  = 1'b1;
         write_rdy = 1'b1;
      end
   end

endmodule

// ==== test/mem_port_model.sv ====
// behavioral memory controller user port
// write data FIFO, command handling, a word memory and read data
// that comes back after a pseudo random delay

`timescale 1ns/1ps

module mem_port_model import host_pkg::*; (
   input  logic        ifclk,
   input  logic        mem_rst,
   input  logic        cmd_en,
   input  logic [2:0]  cmd_instr,
   input  burst_len_t  cmd_bl,
   input  byte_addr_t  cmd_byte_addr,
   input  logic        wr_en,
   input  logic [31:0] wr_data,
   input  logic        rd_en,
   output logic        cmd_full,
   output logic        wr_full,
   output logic        rd_empty,
   output logic [31:0] rd_data,
   output logic        calib_done,
   output logic        wr_error,
   output logic        wr_underrun,
   output logic        rd_error,
   output logic        rd_overflow,
   // flags set by the testbench
   input  logic        hold_cmd_full,
   input  logic        hold_wr_full,
   input  logic        calib_set,
   input  logic [3:0]  err_set,
   output logic        rule_err
);

   logic [31:0] mem [0:1023];
   logic [31:0] wr_q[$];
   logic [31:0] pend_q[$];
   logic [31:0] rd_q[$];
   logic [31:0] lfsr;
   logic [1:0]  delay;
   logic [9:0]  base;
   int          i;
   int          n;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic rule_broken(input string what);
      $display("memory model: %s", what);
      rule_err <= 1'b1;
   endtask

   assign cmd_full   = hold_cmd_full;
   assign wr_full    = hold_wr_full;
   assign calib_done = calib_set;
   assign {rd_overflow, rd_error, wr_underrun, wr_error} = err_set;

   initial begin
      // fill pattern built from the word address
      for (i = 0; i < 1024; i++) begin
         mem[i] = {6'h2b, i[9:0], 6'h14, ~i[9:0]};
      end
      lfsr     = 32'd99203;
      delay    = 2'd0;
      rule_err = 1'b0;
      rd_empty = 1'b1;
      rd_data  = 32'd0;
   end

   always @(posedge ifclk) begin
      if (mem_rst) begin
         wr_q.delete();
         pend_q.delete();
         rd_q.delete();
         rd_empty <= 1'b1;
         rd_data  <= 32'd0;
      end else begin
         if (wr_en) begin
            if (wr_full) rule_broken("write data pushed while wr_full was high");
            wr_q.push_back(wr_data);
         end
         if (rd_en) begin
            if (rd_empty) rule_broken("read data popped while rd_empty was high");
            else void'(rd_q.pop_front());
         end
         if (cmd_en) begin
            base = cmd_byte_addr[11:2];
            if (cmd_full) rule_broken("command pushed while cmd_full was high");
            if (cmd_instr == CMD_WRITE) begin
               if (wr_q.size() < int'(cmd_bl) + 1) begin
                  rule_broken("write command issued before all its data words");
               end else begin
                  for (n = 0; n <= int'(cmd_bl); n++) begin
                     mem[base + 10'(n)] = wr_q.pop_front();
                  end
               end
            end else begin
               for (n = 0; n <= int'(cmd_bl); n++) begin
                  pend_q.push_back(mem[base + 10'(n)]);
               end
            end
         end
         // words move to the read FIFO one at a time, 0 to 3 cycles apart
         if (pend_q.size() != 0) begin
            if (delay == 2'd0) begin
               rd_q.push_back(pend_q.pop_front());
               repeat (2) begin
                  delay = {delay[0], lfsr[0]};
                  lfsr  = lfsr_step(lfsr);
               end
            end else begin
               delay = delay - 2'd1;
            end
         end
         rd_empty <= (rd_q.size() == 0);
         rd_data  <= (rd_q.size() != 0) ? rd_q[0] : 32'd0;
      end
   end

endmodule

// ==== test/tb_host_core.sv ====
// testbench for the host register and DRAM bridge core
// drives host transfers to every terminal and checks the port traffic
// against the memory model

`timescale 1ns/1ps

module tb_host_core import host_pkg::*; ();

   localparam int BURST_WORDS = 16;
   localparam int TIMEOUT     = 500;

   logic        ifclk = 1'b0;
   logic        rst;
   term_addr_t  term_addr;
   logic [31:0] reg_addr;
   logic [31:0] len;
   logic        read_mode;
   logic        read;
   logic        write_mode;
   logic        write;
   reg_word_t   reg_datai;
   reg_word_t   reg_datao;
   logic        read_rdy;
   logic        write_rdy;
   logic        cmd_en;
   logic [2:0]  cmd_instr;
   burst_len_t  cmd_bl;
   byte_addr_t  cmd_byte_addr;
   logic        wr_en;
   logic [31:0] wr_data;
   logic        rd_en;
   logic        mem_rst;
   logic        cmd_full;
   logic        wr_full;
   logic        rd_empty;
   logic [31:0] rd_data;
   logic        calib_done;
   logic        wr_error;
   logic        wr_underrun;
   logic        rd_error;
   logic        rd_overflow;
   logic        hold_cmd_full;
   logic        hold_wr_full;
   logic        calib_set;
   logic [3:0]  err_set;
   logic        rule_err;

   logic [31:0] lfsr_state = 32'd99203;
   reg_word_t   exp_q[$];
   burst_len_t  wr_bl_q[$];
   byte_addr_t  wr_addr_q[$];
   reg_word_t   rd_word;

   always #2 ifclk = ~ifclk;

   host_core #(.BURST_WORDS(BURST_WORDS)) dut_i (
      .ifclk         (ifclk),
      .rst           (rst),
      .term_addr     (term_addr),
      .reg_addr      (reg_addr),
      .len           (len),
      .read_mode     (read_mode),
      .read          (read),
      .write_mode    (write_mode),
      .write         (write),
      .reg_datai     (reg_datai),
      .reg_datao     (reg_datao),
      .read_rdy      (read_rdy),
      .write_rdy     (write_rdy),
      .cmd_en        (cmd_en),
      .cmd_instr     (cmd_instr),
      .cmd_bl        (cmd_bl),
      .cmd_byte_addr (cmd_byte_addr),
      .wr_en         (wr_en),
      .wr_data       (wr_data),
      .rd_en         (rd_en),
      .mem_rst       (mem_rst),
      .cmd_full      (cmd_full),
      .wr_full       (wr_full),
      .rd_empty      (rd_empty),
      .rd_data       (rd_data),
      .calib_done    (calib_done),
      .wr_error      (wr_error),
      .wr_underrun   (wr_underrun),
      .rd_error      (rd_error),
      .rd_overflow   (rd_overflow)
   );

   mem_port_model mem_i (
      .ifclk         (ifclk),
      .mem_rst       (mem_rst),
      .cmd_en        (cmd_en),
      .cmd_instr     (cmd_instr),
      .cmd_bl        (cmd_bl),
      .cmd_byte_addr (cmd_byte_addr),
      .wr_en         (wr_en),
      .wr_data       (wr_data),
      .rd_en         (rd_en),
      .cmd_full      (cmd_full),
      .wr_full       (wr_full),
      .rd_empty      (rd_empty),
      .rd_data       (rd_data),
      .calib_done    (calib_done),
      .wr_error      (wr_error),
      .wr_underrun   (wr_underrun),
      .rd_error      (rd_error),
      .rd_overflow   (rd_overflow),
      .hold_cmd_full (hold_cmd_full),
      .hold_wr_full  (hold_wr_full),
      .calib_set     (calib_set),
      .err_set       (err_set),
      .rule_err      (rule_err)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("FAIL: see errors above");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
      assert (got === exp)
         else abort_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // one LFSR step per data bit
   task automatic rand_word(output reg_word_t w);
      int b;
      w = '0;
      for (b = 0; b < 16; b++) begin
         w          = {w[14:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   // write commands seen on the port are collected per transfer
   always @(posedge ifclk) begin
      if (cmd_en === 1'b1 && cmd_instr == CMD_WRITE) begin
         wr_bl_q.push_back(cmd_bl);
         wr_addr_q.push_back(cmd_byte_addr);
      end
      assert (rule_err !== 1'b1)
         else abort_run("the memory model saw a broken port rule");
   end

   // polls the ready level seen just before the current clock edge
   task automatic wait_ready(input logic for_read);
      int n;
      n = 0;
      while ((for_read ? read_rdy : write_rdy) !== 1'b1) begin
         @(posedge ifclk);
         n++;
         if (n > TIMEOUT) begin
            abort_run($sformatf("timed out waiting for %s",
                                for_read ? "read_rdy" : "write_rdy"));
         end
      end
   endtask

   task automatic reg_read(input term_addr_t term, input logic [31:0] addr,
                           output reg_word_t d);
      term_addr <= term;
      reg_addr  <= addr;
      read_mode <= 1'b1;
      @(posedge ifclk);
      wait_ready(1'b1);
      d = reg_datao;
      read <= 1'b1;
      @(posedge ifclk);
      read      <= 1'b0;
      read_mode <= 1'b0;
      @(posedge ifclk);
   endtask

   task automatic reg_write(input term_addr_t term, input logic [31:0] addr,
                            input reg_word_t d);
      term_addr  <= term;
      reg_addr   <= addr;
      write_mode <= 1'b1;
      @(posedge ifclk);
      wait_ready(1'b0);
      write     <= 1'b1;
      reg_datai <= d;
      @(posedge ifclk);
      write      <= 1'b0;
      write_mode <= 1'b0;
      @(posedge ifclk);
   endtask

   // two idle cycles let a burst-full stall show up on write_rdy
   task automatic write_half(input reg_word_t d, input logic stall);
      wait_ready(1'b0);
      write     <= 1'b1;
      reg_datai <= d;
      @(posedge ifclk);
      write <= 1'b0;
      if (stall) begin
         // a just finished burst has to wait for its command
         hold_port(1'b0, 1'b1);
         hold_port(1'b1, 1'b0);
      end else begin
         repeat (2) @(posedge ifclk);
      end
   endtask

   task automatic hold_port(input logic wf, input logic cf);
      hold_wr_full  <= wf;
      hold_cmd_full <= cf;
      @(posedge ifclk);
      repeat (6) begin
         @(posedge ifclk);
         check_eq("write_rdy", write_rdy, 32'd0);
         check_eq("wr_en", wr_en, 32'd0);
         check_eq("cmd_en", cmd_en, 32'd0);
      end
      hold_wr_full  <= 1'b0;
      hold_cmd_full <= 1'b0;
      @(posedge ifclk);
   endtask

   // expected split is full bursts first and then the remainder
   // address steps by 4 per word
   task automatic check_write_cmds(input logic [31:0] addr, input int n);
      int words;
      int bursts;
      int sent;
      int cnt;
      int b;
      int waited;
      words  = (n + 1) / 2;
      bursts = (words + BURST_WORDS - 1) / BURST_WORDS;
      waited = 0;
      while (wr_bl_q.size() < bursts) begin
         @(posedge ifclk);
         waited++;
         if (waited > TIMEOUT) abort_run("timed out waiting for the write commands");
      end
      repeat (4) @(posedge ifclk);
      check_eq("write command count", wr_bl_q.size(), bursts);
      sent = 0;
      for (b = 0; b < bursts; b++) begin
         cnt = (words - sent > BURST_WORDS) ? BURST_WORDS : words - sent;
         check_eq("cmd_bl", wr_bl_q[b], cnt - 1);
         check_eq("cmd_byte_addr", wr_addr_q[b], addr + 4 * sent);
         sent += cnt;
      end
   endtask

   task automatic dram_write(input logic [31:0] addr, input int n, input int stall_at);
      int k;
      reg_word_t d;
      exp_q.delete();
      wr_bl_q.delete();
      wr_addr_q.delete();
      term_addr  <= TERM_DRAM;
      reg_addr   <= addr;
      write_mode <= 1'b1;
      repeat (2) @(posedge ifclk);
      for (k = 0; k < n; k++) begin
         rand_word(d);
         exp_q.push_back(d);
         write_half(d, k == stall_at);
      end
      write_mode <= 1'b0;
      @(posedge ifclk);
      check_write_cmds(addr, n);
   endtask

   task automatic dram_read(input logic [31:0] addr, input int n);
      int k;
      term_addr <= TERM_DRAM;
      reg_addr  <= addr;
      len       <= n;
      read_mode <= 1'b1;
      @(posedge ifclk);
      for (k = 0; k < n; k++) begin
         wait_ready(1'b1);
         check_eq("reg_datao", reg_datao, exp_q[k]);
         read <= 1'b1;
         @(posedge ifclk);
         read <= 1'b0;
         @(posedge ifclk);
      end
      // nothing past len
      repeat (4) begin
         check_eq("read_rdy", read_rdy, 32'd0);
         @(posedge ifclk);
      end
      read_mode <= 1'b0;
      @(posedge ifclk);
   endtask

   initial begin
      rst           = 1'b1;
      term_addr     = '0;
      reg_addr      = '0;
      len           = '0;
      read_mode     = 1'b0;
      read          = 1'b0;
      write_mode    = 1'b0;
      write         = 1'b0;
      reg_datai     = '0;
      hold_cmd_full = 1'b0;
      hold_wr_full  = 1'b0;
      calib_set     = 1'b0;
      err_set       = 4'd0;

      // port quiet and controller held in reset for the 4 reset cycles
      @(posedge ifclk);
      repeat (3) begin
         @(posedge ifclk);
         check_eq("cmd_en", cmd_en, 32'd0);
         check_eq("wr_en", wr_en, 32'd0);
         check_eq("rd_en", rd_en, 32'd0);
         check_eq("mem_rst", mem_rst, 32'd1);
      end
      rst <= 1'b0;
      @(posedge ifclk);
      check_eq("mem_rst", mem_rst, 32'd0);
      check_eq("cmd_en", cmd_en, 32'd0);
      check_eq("wr_en", wr_en, 32'd0);
      check_eq("rd_en", rd_en, 32'd0);
      reg_read(TERM_DRAM_CTRL, CTRL_REG_RESET, rd_word);
      check_eq("reset register", rd_word, 32'd0);

      reg_read(TERM_DUMMY, 32'd0, rd_word);
      check_eq("dummy word", rd_word, 32'h9988);
      reg_read(16'h0042, 32'd0, rd_word);
      check_eq("unknown terminal data", rd_word, 32'd0);
      check_eq("read_rdy", read_rdy, 32'd1);
      check_eq("write_rdy", write_rdy, 32'd1);

      reg_write(TERM_DRAM_CTRL, CTRL_REG_RESET, 16'h0001);
      check_eq("mem_rst", mem_rst, 32'd1);
      reg_read(TERM_DRAM_CTRL, CTRL_REG_RESET, rd_word);
      check_eq("reset register", rd_word, 32'd1);

      // status bit order is calib_done then wr_error, wr_underrun, rd_error and rd_overflow
      {err_set, calib_set} <= 5'b10101;
      repeat (2) @(posedge ifclk);
      reg_read(TERM_DRAM_CTRL, CTRL_REG_STATUS, rd_word);
      check_eq("status word", rd_word, 32'h15);
      {err_set, calib_set} <= 5'b01011;
      repeat (2) @(posedge ifclk);
      reg_read(TERM_DRAM_CTRL, CTRL_REG_STATUS, rd_word);
      check_eq("status word", rd_word, 32'h0b);
      {err_set, calib_set} <= 5'b00001;
      reg_write(TERM_DRAM_CTRL, CTRL_REG_RESET, 16'h0000);
      check_eq("mem_rst", mem_rst, 32'd0);

      // odd length leaves a zero high half in the last port word
      dram_write(32'h100, 2 * BURST_WORDS + 3, -1);
      exp_q.push_back(16'h0000);
      dram_read(32'h100, 2 * BURST_WORDS + 4);
      dram_read(32'h100, 7);

      // back-pressure while the first burst command is pending
      dram_write(32'h400, 40, 2 * BURST_WORDS - 1);
      dram_read(32'h400, 40);

      $display("PASS: all tests");
      $finish;
   end

endmodule

// ==== verilog.f ====
hw/host_pkg.sv
hw/term_router.sv
hw/dram_ctrl_regs.sv
hw/dram_write_path.sv
hw/dram_read_path.sv
hw/host_core.sv
test/mem_port_model.sv
test/tb_host_core.sv
